// ==== ym_map_pkg.sv ====
package ym_map_pkg;

	// --------------------------------------------------
	// 68000 map, compared on a23..a8
	// --------------------------------------------------
	localparam logic [15:0] M68K_IO_BASE     = 16'hA100; // version, pads.
	localparam logic [15:0] M68K_BUSREQ_ADDR = 16'hA111;
	localparam logic [15:0] M68K_RESET_ADDR  = 16'hA112;
	localparam logic [15:0] M68K_FDC_BASE    = 16'hA120;
	localparam logic [15:0] M68K_TIME_BASE   = 16'hA130;

	// --------------------------------------------------
	// Z80 map, compared on a15..a8
	// --------------------------------------------------
	localparam logic [1:0] Z80_ZRAM_TOP     = 2'b00;  // 0000-3fff.
	localparam logic [2:0] Z80_SOUND_TOP    = 3'b010; // 4000-5fff.
	localparam logic [7:0] Z80_BANK_WR_ADDR = 8'h60;  // 6000-60ff.

	// a15 within the sampled z80 page.
	localparam int unsigned Z80_WINDOW_BIT = 7;

	// bank register becomes a23..a15.
	localparam int unsigned BANK_WIDTH = 9;

endpackage

// ==== ym_bus_pkg.sv ====
package ym_bus_pkg;

	import ym_map_pkg::*;

	typedef logic [15:0] m68k_addr_t;           // a23..a8.
	typedef logic [7:0] z80_addr_t;             // a15..a8.
	typedef logic [BANK_WIDTH-1:0] z80_bank_t;  // window a23..a15.

	// --------------------------------------------------
	// registered 68000 decode
	// --------------------------------------------------
	typedef struct packed {
		logic io;
		logic timer;
		logic fdc;
		logic busreq_reg;
		logic reset_reg;
		logic wr;  // one cycle per bus write.
		logic d8;
	} m68k_sel_t;

	// --------------------------------------------------
	// registered Z80 decode
	// --------------------------------------------------
	typedef struct packed {
		logic      zram;
		logic      sound;
		logic      bank_wr;
		logic      window;
		z80_addr_t za;
		logic      d0;
	} z80_sel_t;

	// Z80 control register outputs.
	typedef struct packed {
		logic      busreq;
		logic      z80_reset;
		z80_bank_t bank;
	} z80_ctl_t;

endpackage

// ==== m68k_decode.sv ====
`timescale 1ns/1ps

module m68k_decode
	import ym_bus_pkg::*, ym_map_pkg::*;
(
	input  logic       MCLK,
	input  logic       rst_n_i,
	input  m68k_addr_t va_i,
	input  logic       as_n_i,
	input  logic       uds_n_i,
	input  logic       rw_i,
	input  logic       vd8_i,
	output m68k_sel_t  m68k_sel_o
);

	m68k_addr_t va_q;
	logic       vd8_q;
	logic       as_n_q;
	logic       uds_n_q;
	logic       rw_q;
	logic       wr_cyc;
	logic       wr_cyc_d;
	logic       wr_start;
	m68k_sel_t  sel_q;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			as_n_q  <= 1'b1;
			uds_n_q <= 1'b1;
			rw_q    <= 1'b1;
		end
		else
		begin
			as_n_q  <= as_n_i;
			uds_n_q <= uds_n_i;
			rw_q    <= rw_i;
		end
	end

	always_ff @(posedge MCLK)
	begin
		va_q  <= va_i;
		vd8_q <= vd8_i;
	end

	assign wr_cyc   = ~as_n_q & ~uds_n_q & ~rw_q; // upper byte write.
	assign wr_start = wr_cyc & ~wr_cyc_d;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sel_q    <= '0;
			wr_cyc_d <= 1'b0;
		end
		else
		begin
			sel_q.io         <= ~as_n_q && (va_q == M68K_IO_BASE);
			sel_q.timer      <= ~as_n_q && (va_q == M68K_TIME_BASE);
			sel_q.fdc        <= ~as_n_q && (va_q == M68K_FDC_BASE);
			sel_q.busreq_reg <= ~as_n_q && (va_q == M68K_BUSREQ_ADDR);
			sel_q.reset_reg  <= ~as_n_q && (va_q == M68K_RESET_ADDR);
			sel_q.wr         <= wr_start;
			if (wr_start)
				sel_q.d8 <= vd8_q; // held until next write.
			wr_cyc_d <= wr_cyc;
		end
	end

	assign m68k_sel_o = sel_q;

endmodule

// ==== z80_decode.sv ====
`timescale 1ns/1ps

module z80_decode
	import ym_bus_pkg::*, ym_map_pkg::*;
(
	input  logic      MCLK,
	input  logic      rst_n_i,
	input  z80_addr_t za_i,
	input  logic      mreq_n_i,
	input  logic      zwr_n_i,
	input  logic      zd0_i,
	output z80_sel_t  z80_sel_o
);

	z80_addr_t za_q;
	logic      zd0_q;
	logic      mreq_n_q;
	logic      zwr_n_q;
	logic      bank_cyc;
	logic      bank_cyc_d;
	logic      bank_start;
	z80_sel_t  sel_q;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			mreq_n_q <= 1'b1;
			zwr_n_q  <= 1'b1;
		end
		else
		begin
			mreq_n_q <= mreq_n_i;
			zwr_n_q  <= zwr_n_i;
		end
	end

	always_ff @(posedge MCLK)
	begin
		za_q  <= za_i;
		zd0_q <= zd0_i;
	end

	assign bank_cyc   = ~mreq_n_q & ~zwr_n_q & (za_q == Z80_BANK_WR_ADDR);
	assign bank_start = bank_cyc & ~bank_cyc_d;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sel_q      <= '0;
			bank_cyc_d <= 1'b0;
		end
		else
		begin
			sel_q.zram    <= ~mreq_n_q && (za_q[7:6] == Z80_ZRAM_TOP);
			sel_q.sound   <= ~mreq_n_q && (za_q[7:5] == Z80_SOUND_TOP);
			sel_q.window  <= ~mreq_n_q & za_q[Z80_WINDOW_BIT]; // 8000-ffff.
			sel_q.za      <= za_q;
			sel_q.bank_wr <= bank_start;
			if (bank_start)
				sel_q.d0 <= zd0_q;
			bank_cyc_d <= bank_cyc;
		end
	end

	assign z80_sel_o = sel_q;

endmodule

// ==== z80_regs.sv ====
`timescale 1ns/1ps

module z80_regs
	import ym_bus_pkg::*;
(
	input  logic      MCLK,
	input  logic      rst_n_i,
	input  m68k_sel_t m68k_sel_i,
	input  z80_sel_t  z80_sel_i,
	output z80_ctl_t  ctl_o
);

	z80_ctl_t ctl_q;
	logic     busreq_wr;
	logic     reset_wr;

	assign busreq_wr = m68k_sel_i.wr & m68k_sel_i.busreq_reg;
	assign reset_wr  = m68k_sel_i.wr & m68k_sel_i.reset_reg;

	// --------------------------------------------------
	// control bits, written from the 68000
	// --------------------------------------------------
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ctl_q.busreq    <= 1'b0;
			ctl_q.z80_reset <= 1'b1; // z80 held after reset.
		end
		else
		begin
			if (busreq_wr)
				ctl_q.busreq <= m68k_sel_i.d8;
			if (reset_wr)
				ctl_q.z80_reset <= ~m68k_sel_i.d8; // 1 releases.
		end
	end

	// --------------------------------------------------
	// bank register, serial from the z80
	// --------------------------------------------------
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ctl_q.bank <= '0;
		end
		else if (z80_sel_i.bank_wr)
		begin
			// d0 enters at a23, older bits move down.
			ctl_q.bank <= {z80_sel_i.d0, ctl_q.bank[$bits(z80_bank_t)-1:1]};
		end
	end

	assign ctl_o = ctl_q;

endmodule

// ==== bus_out.sv ====
`timescale 1ns/1ps

module bus_out
	import ym_bus_pkg::*;
(
	input  m68k_sel_t  m68k_sel_i,
	input  z80_sel_t   z80_sel_i,
	input  z80_ctl_t   ctl_i,
	input  logic       zbak_n_i,
	output logic       io_n_o,
	output logic       time_n_o,
	output logic       fdc_n_o,
	output logic       dtack_n_o,
	output logic       zram_n_o,
	output logic       sound_n_o,
	output logic       zbr_n_o,
	output logic       zres_n_o,
	output logic       vz_n_o,
	output m68k_addr_t va_o,
	output logic       vd8_o
);

	logic ctl_sel;

	assign ctl_sel = m68k_sel_i.busreq_reg | m68k_sel_i.reset_reg;

	// --------------------------------------------------
	// 68000 side
	// --------------------------------------------------
	assign io_n_o    = ~m68k_sel_i.io;
	assign time_n_o  = ~m68k_sel_i.timer;
	assign fdc_n_o   = ~m68k_sel_i.fdc;
	assign dtack_n_o = ~ctl_sel; // only the local registers.

	// bus acknowledge readback on d8.
	assign vd8_o = ctl_i.busreq ? zbak_n_i : 1'b1;

	// --------------------------------------------------
	// Z80 side
	// --------------------------------------------------
	assign zram_n_o  = ~z80_sel_i.zram;
	assign sound_n_o = ~z80_sel_i.sound;
	assign zbr_n_o   = ~ctl_i.busreq;
	assign zres_n_o  = ~ctl_i.z80_reset;
	assign vz_n_o    = ~z80_sel_i.window;

	// window address, bank above z80 a14..a8.
	always_comb
	begin
		if (z80_sel_i.window)
			va_o = {ctl_i.bank, z80_sel_i.za[6:0]};
		else
			va_o = '0;
	end

endmodule

// ==== ym6045_top.sv ====
`timescale 1ns/1ps

module ym6045_top
	import ym_bus_pkg::*;
(
	input  logic       MCLK,
	input  logic       rst_n_i,
	input  m68k_addr_t va_i,
	input  logic       as_n_i,
	input  logic       uds_n_i,
	input  logic       rw_i,
	input  logic       vd8_i,
	input  z80_addr_t  za_i,
	input  logic       mreq_n_i,
	input  logic       zwr_n_i,
	input  logic       zd0_i,
	input  logic       zbak_n_i,
	output logic       io_n_o,
	output logic       time_n_o,
	output logic       fdc_n_o,
	output logic       dtack_n_o,
	output logic       zram_n_o,
	output logic       sound_n_o,
	output logic       zbr_n_o,
	output logic       zres_n_o,
	output logic       vz_n_o,
	output m68k_addr_t va_o,
	output logic       vd8_o
);

	m68k_sel_t m68k_sel;
	z80_sel_t  z80_sel;
	z80_ctl_t  ctl;

	m68k_decode u_m68k_decode (
		.MCLK       (MCLK),
		.rst_n_i    (rst_n_i),
		.va_i       (va_i),
		.as_n_i     (as_n_i),
		.uds_n_i    (uds_n_i),
		.rw_i       (rw_i),
		.vd8_i      (vd8_i),
		.m68k_sel_o (m68k_sel)
	);

	z80_decode u_z80_decode (
		.MCLK      (MCLK),
		.rst_n_i   (rst_n_i),
		.za_i      (za_i),
		.mreq_n_i  (mreq_n_i),
		.zwr_n_i   (zwr_n_i),
		.zd0_i     (zd0_i),
		.z80_sel_o (z80_sel)
	);

	z80_regs u_z80_regs (
		.MCLK       (MCLK),
		.rst_n_i    (rst_n_i),
		.m68k_sel_i (m68k_sel),
		.z80_sel_i  (z80_sel),
		.ctl_o      (ctl)
	);

	bus_out u_bus_out (
		.m68k_sel_i (m68k_sel),
		.z80_sel_i  (z80_sel),
		.ctl_i      (ctl),
		.zbak_n_i   (zbak_n_i),
		.io_n_o     (io_n_o),
		.time_n_o   (time_n_o),
		.fdc_n_o    (fdc_n_o),
		.dtack_n_o  (dtack_n_o),
		.zram_n_o   (zram_n_o),
		.sound_n_o  (sound_n_o),
		.zbr_n_o    (zbr_n_o),
		.zres_n_o   (zres_n_o),
		.vz_n_o     (vz_n_o),
		.va_o       (va_o),
		.vd8_o      (vd8_o)
	);

endmodule

// ==== tb_ym6045.sv ====
`timescale 1ns/1ps

module tb_ym6045
	import ym_bus_pkg::*;
();

	localparam int WAIT_LIMIT = 20;
	localparam int LATENCY    = 2;
	localparam int RUN_LIMIT  = 20000;
	localparam int OUT_ZBR    = 0;
	localparam int OUT_ZRES   = 1;
	localparam int OUT_DTACK  = 2;
	localparam int OUT_VZ     = 3;

	logic       MCLK;
	logic       rst_n_i;
	m68k_addr_t va_i;
	logic       as_n_i;
	logic       uds_n_i;
	logic       rw_i;
	logic       vd8_i;
	z80_addr_t  za_i;
	logic       mreq_n_i;
	logic       zwr_n_i;
	logic       zd0_i;
	logic       zbak_n_i;
	logic       io_n_o;
	logic       time_n_o;
	logic       fdc_n_o;
	logic       dtack_n_o;
	logic       zram_n_o;
	logic       sound_n_o;
	logic       zbr_n_o;
	logic       zres_n_o;
	logic       vz_n_o;
	m68k_addr_t va_o;
	logic       vd8_o;

	integer     seed;
	z80_bank_t  bank_model; // reference copy of the bank register.
	m68k_addr_t addr;
	z80_addr_t  zaddr;
	logic       bit_v;
	logic [2:0] exp_sel;

	ym6045_top DUT (.*);

	initial
	begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
			stop_on_error();
		end
	endtask

	function automatic logic pick_output(input int sel);
		case (sel)
			OUT_ZBR:   pick_output = zbr_n_o;
			OUT_ZRES:  pick_output = zres_n_o;
			OUT_DTACK: pick_output = dtack_n_o;
			default:   pick_output = vz_n_o;
		endcase
	endfunction

	// polls on the falling edge between register updates.
	task automatic wait_output(input int sel, input logic exp, input string name);
		int n;
		n = 0;
		@(negedge MCLK);
		while (pick_output(sel) !== exp && n < WAIT_LIMIT)
		begin
			n++;
			@(negedge MCLK);
		end
		if (pick_output(sel) !== exp)
		begin
			$display("Timed out waiting for %s to reach %0b", name, exp);
			stop_on_error();
		end
	endtask

	task automatic settle(input int n);
		for (int i = 0; i < n; i++)
			@(posedge MCLK);
		@(negedge MCLK);
	endtask

	task automatic m68k_start(input m68k_addr_t a, input logic write, input logic data);
		@(posedge MCLK);
		va_i    <= a;
		as_n_i  <= 1'b0;
		uds_n_i <= 1'b0;
		rw_i    <= ~write;
		vd8_i   <= data;
	endtask

	task automatic m68k_end();
		@(posedge MCLK);
		as_n_i  <= 1'b1;
		uds_n_i <= 1'b1;
		rw_i    <= 1'b1;
	endtask

	task automatic z80_start(input z80_addr_t a, input logic write, input logic data);
		@(posedge MCLK);
		za_i     <= a;
		mreq_n_i <= 1'b0;
		zwr_n_i  <= ~write;
		zd0_i    <= data;
	endtask

	task automatic z80_end();
		@(posedge MCLK);
		mreq_n_i <= 1'b1;
		zwr_n_i  <= 1'b1;
	endtask

	// expected io, timer and fdc selects as active high bits.
	function automatic logic [2:0] m68k_expect(input m68k_addr_t a);
		m68k_expect = {a == 16'hA100, a == 16'hA130, a == 16'hA120};
	endfunction

	// --------------------------------------------------
	// bus invariants
	// --------------------------------------------------
	window_addr_zero: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		vz_n_o |-> (va_o == 16'h0000))
	else
	begin
		$display("Error at %0t ns: va_o expected 0 got %h", $time, va_o);
		stop_on_error();
	end

	m68k_sel_onehot: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		$onehot0(~{io_n_o, time_n_o, fdc_n_o}))
	else
	begin
		$display("Error at %0t ns: 68000 selects expected one-hot got %b", $time,
			{io_n_o, time_n_o, fdc_n_o});
		stop_on_error();
	end

	initial
	begin
		repeat (RUN_LIMIT) @(posedge MCLK);
		$display("Simulation ran past its cycle limit");
		$display("Some tests failed");
		$fatal(1, "run limit reached");
	end

	initial
	begin
		seed       = 32'h4c22_5811;
		bank_model = '0;
		rst_n_i    = 1'b0;
		va_i       = '0;
		as_n_i     = 1'b1;
		uds_n_i    = 1'b1;
		rw_i       = 1'b1;
		vd8_i      = 1'b0;
		za_i       = '0;
		mreq_n_i   = 1'b1;
		zwr_n_i    = 1'b1;
		zd0_i      = 1'b0;
		zbak_n_i   = 1'b1;
		repeat (8) @(posedge MCLK);
		rst_n_i <= 1'b1;

		@(negedge MCLK);
		check_val("io_n_o", io_n_o, 1);
		check_val("time_n_o", time_n_o, 1);
		check_val("fdc_n_o", fdc_n_o, 1);
		check_val("zram_n_o", zram_n_o, 1);
		check_val("sound_n_o", sound_n_o, 1);
		check_val("vz_n_o", vz_n_o, 1);
		check_val("dtack_n_o", dtack_n_o, 1);
		check_val("zbr_n_o", zbr_n_o, 1);
		check_val("zres_n_o", zres_n_o, 0);
		check_val("va_o", va_o, 0);

		// --------------------------------------------------
		// bus request register
		// --------------------------------------------------
		m68k_start(16'hA111, 1'b1, 1'b1);
		wait_output(OUT_ZBR, 1'b0, "zbr_n_o");
		check_val("dtack_n_o", dtack_n_o, 0);
		m68k_end();
		wait_output(OUT_DTACK, 1'b1, "dtack_n_o");
		for (int k = 0; k < 4; k++)
		begin
			bit_v = $random(seed);
			m68k_start(16'hA111, 1'b0, 1'b0);
			zbak_n_i <= bit_v;
			wait_output(OUT_DTACK, 1'b0, "dtack_n_o");
			check_val("vd8_o", vd8_o, bit_v);
			m68k_end();
			wait_output(OUT_DTACK, 1'b1, "dtack_n_o");
		end
		m68k_start(16'hA111, 1'b1, 1'b0);
		wait_output(OUT_ZBR, 1'b1, "zbr_n_o");
		m68k_end();
		wait_output(OUT_DTACK, 1'b1, "dtack_n_o");
		check_val("vd8_o", vd8_o, 1);

		// writing 1 to the reset register releases the z80.
		m68k_start(16'hA112, 1'b1, 1'b1);
		wait_output(OUT_ZRES, 1'b1, "zres_n_o");
		m68k_end();
		wait_output(OUT_DTACK, 1'b1, "dtack_n_o");
		m68k_start(16'hA112, 1'b1, 1'b0);
		wait_output(OUT_ZRES, 1'b0, "zres_n_o");
		m68k_end();
		wait_output(OUT_DTACK, 1'b1, "dtack_n_o");

		// --------------------------------------------------
		// bank register and window
		// --------------------------------------------------
		for (int r = 0; r < 2; r++)
		begin
			for (int b = 0; b < 9; b++)
			begin
				bit_v = $random(seed);
				z80_start(8'h60, 1'b1, bit_v);
				repeat (2 + ($random(seed) & 3)) @(posedge MCLK); // one pulse per cycle.
				z80_end();
				bank_model = {bit_v, bank_model[8:1]};
				settle(LATENCY);
			end
			for (int w = 0; w < 4; w++)
			begin
				zaddr = {1'b1, 7'($random(seed))};
				z80_start(zaddr, 1'b0, 1'b0);
				wait_output(OUT_VZ, 1'b0, "vz_n_o");
				check_val("va_o", va_o, {bank_model, zaddr[6:0]});
				check_val("zram_n_o", zram_n_o, 1);
				check_val("sound_n_o", sound_n_o, 1);
				z80_end();
				wait_output(OUT_VZ, 1'b1, "vz_n_o");
			end
		end

		// --------------------------------------------------
		// 68000 region decode
		// --------------------------------------------------
		for (int t = 0; t < 24; t++)
		begin
			case ($random(seed) & 3)
				0: addr = 16'hA100;
				1: addr = 16'hA130;
				2: addr = 16'hA120;
				default: addr = {8'hA1, 8'($random(seed))};
			endcase
			exp_sel = m68k_expect(addr);
			m68k_start(addr, 1'b0, 1'b0);
			settle(LATENCY);
			check_val("68000 selects", {~io_n_o, ~time_n_o, ~fdc_n_o}, exp_sel);
			check_val("dtack_n_o", dtack_n_o, !(addr == 16'hA111 || addr == 16'hA112));
			m68k_end();
			settle(LATENCY);
			check_val("68000 selects idle", {io_n_o, time_n_o, fdc_n_o, dtack_n_o}, 4'hf);
		end

		// z80 region decode with reads only.
		for (int t = 0; t < 24; t++)
		begin
			zaddr = $random(seed);
			z80_start(zaddr, 1'b0, 1'b0);
			settle(LATENCY);
			check_val("zram_n_o", zram_n_o, !(zaddr[7:6] == 2'b00));
			check_val("sound_n_o", sound_n_o, !(zaddr[7:5] == 3'b010));
			check_val("vz_n_o", vz_n_o, !zaddr[7]);
			if (zaddr[7])
				check_val("va_o", va_o, {bank_model, zaddr[6:0]});
			z80_end();
			settle(LATENCY);
			check_val("z80 selects idle", {zram_n_o, sound_n_o, vz_n_o}, 3'b111);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== list.f ====
ym_map_pkg.sv
ym_bus_pkg.sv
m68k_decode.sv
z80_decode.sv
z80_regs.sv
bus_out.sv
ym6045_top.sv
tb_ym6045.sv

// ==== Bender.yml ====
package:
  name: ym6045

sources:
  - ym_map_pkg.sv
  - ym_bus_pkg.sv
  - m68k_decode.sv
  - z80_decode.sv
  - z80_regs.sv
  - bus_out.sv
  - ym6045_top.sv
  - target: test
    files:
      - tb_ym6045.sv
